/* Makefile */
# Verilator build and run for the pattern streamer testbench

VERILATOR ?= verilator
TOP       ?= pattern_streamer_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := TESTBENCH PASSED

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) include/streamer_params.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/pattern_fifo.sv */
`timescale 1ns/10ps
`include "streamer_params.svh"

module pattern_fifo
   import streamer_pkg::*;
#(
   parameter int DEPTH = `STREAM_FIFO_DEPTH
) (
   input  logic                      clk,
   input  logic                      resetn,
   input  logic                      clear,
   input  logic                      push,
   input  logic [`STREAM_DATA_W-1:0] push_data,
   input  logic                      pop,
   output logic [`STREAM_DATA_W-1:0] head_data,
   output fifo_stat_t                stat
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = `STREAM_CNT_W;
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

   // Pattern storage
   logic [`STREAM_DATA_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]          rd_ptr;
   logic [PTR_W-1:0]          wr_ptr;
   logic [CNT_W-1:0]          count;
   logic                      do_pop;
   logic                      do_push;

   // Pointer wrap also works for depths that are not a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // The write-back of a popped word owns the write slot that cycle
   assign do_pop  = pop && (count != '0);
   assign do_push = push && !pop && (count != FULL_CNT);

   //==================================================
   // Pointers and count
   //==================================================
   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else if (do_pop) begin
         // Head moves to the tail, count unchanged
         rd_ptr <= ptr_inc(rd_ptr);
         wr_ptr <= ptr_inc(wr_ptr);
      end else if (do_push) begin
         wr_ptr <= ptr_inc(wr_ptr);
         count  <= count + 1'b1;
      end
   end

   // Storage write, popped word or newly loaded word
   always_ff @(posedge clk) begin
      if (do_pop) begin
         mem[wr_ptr] <= mem[rd_ptr];
      end else if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   assign head_data     = mem[rd_ptr];
   assign stat.count    = count;
   assign stat.nonempty = (count != '0);

endmodule

/* design/pattern_streamer.sv */
`timescale 1ns/10ps
`include "streamer_params.svh"

module pattern_streamer
   import streamer_pkg::*;
(
   input  logic                      clk,
   input  logic                      resetn,
   input  reg_req_t                  reg_req,
   output reg_rsp_t                  reg_rsp,
   output logic [`STREAM_DATA_W-1:0] stream_data,
   output logic                      stream_valid,
   input  logic                      stream_ready,
   output logic                      sys_resetn
);

   // Register block to FIFOs
   logic                      load_f0;
   logic                      load_f1;
   logic [`STREAM_DATA_W-1:0] load_data;
   logic                      fifo_clear;
   // Register block to sequencer
   fifo_sel_t                 on_deck;
   logic                      cont_mode;
   logic [`STREAM_DATA_W-1:0] nshot_limit;
   // FIFOs to sequencer and register block
   fifo_stat_t                f0_stat;
   fifo_stat_t                f1_stat;
   logic [`STREAM_DATA_W-1:0] f0_data;
   logic [`STREAM_DATA_W-1:0] f1_data;
   // Sequencer outputs
   fifo_sel_t                 active;
   logic                      pop_f0;
   logic                      pop_f1;

   //==================================================
   // Register port and soft reset
   //==================================================
   stream_regs stream_regs_inst (
      .clk         (clk),
      .resetn      (resetn),
      .reg_req     (reg_req),
      .reg_rsp     (reg_rsp),
      .f0_stat     (f0_stat),
      .f1_stat     (f1_stat),
      .active      (active),
      .load_f0     (load_f0),
      .load_f1     (load_f1),
      .load_data   (load_data),
      .on_deck     (on_deck),
      .cont_mode   (cont_mode),
      .nshot_limit (nshot_limit),
      .fifo_clear  (fifo_clear),
      .sys_resetn  (sys_resetn)
   );

   //==================================================
   // Pattern FIFOs
   //==================================================
   pattern_fifo #(.DEPTH(`STREAM_FIFO_DEPTH)) f0 (
      .clk       (clk),
      .resetn    (resetn),
      .clear     (fifo_clear),
      .push      (load_f0),
      .push_data (load_data),
      .pop       (pop_f0),
      .head_data (f0_data),
      .stat      (f0_stat)
   );

   pattern_fifo #(.DEPTH(`STREAM_FIFO_DEPTH)) f1 (
      .clk       (clk),
      .resetn    (resetn),
      .clear     (fifo_clear),
      .push      (load_f1),
      .push_data (load_data),
      .pop       (pop_f1),
      .head_data (f1_data),
      .stat      (f1_stat)
   );

   // Output stream
   stream_sequencer stream_sequencer_inst (
      .clk          (clk),
      .resetn       (resetn),
      .clear        (fifo_clear),
      .on_deck      (on_deck),
      .cont_mode    (cont_mode),
      .nshot_limit  (nshot_limit),
      .f0_stat      (f0_stat),
      .f1_stat      (f1_stat),
      .f0_data      (f0_data),
      .f1_data      (f1_data),
      .active       (active),
      .pop_f0       (pop_f0),
      .pop_f1       (pop_f1),
      .stream_data  (stream_data),
      .stream_valid (stream_valid),
      .stream_ready (stream_ready)
   );

endmodule

/* design/stream_regs.sv */
`timescale 1ns/10ps
`include "streamer_params.svh"

module stream_regs
   import streamer_pkg::*;
(
   input  logic                      clk,
   input  logic                      resetn,
   input  reg_req_t                  reg_req,
   output reg_rsp_t                  reg_rsp,
   input  fifo_stat_t                f0_stat,
   input  fifo_stat_t                f1_stat,
   input  fifo_sel_t                 active,
   output logic                      load_f0,
   output logic                      load_f1,
   output logic [`STREAM_DATA_W-1:0] load_data,
   output fifo_sel_t                 on_deck,
   output logic                      cont_mode,
   output logic [`STREAM_DATA_W-1:0] nshot_limit,
   output logic                      fifo_clear,
   output logic                      sys_resetn
);

   localparam int DW     = `STREAM_DATA_W;
   localparam int CNT_W  = `STREAM_CNT_W;
   localparam int SRST_W = $clog2(`STREAM_SRST_CYCLES + 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`STREAM_FIFO_DEPTH);

   // Soft-reset down-counter, nonzero while the downstream reset is held
   logic [SRST_W-1:0] srst_cnt;
   logic              srst_active;
   logic              srst_start;
   // Request decode
   logic              f0_blocked;
   logic              f1_blocked;
   logic              wr_err;
   logic              wr_ok;
   logic              rd_err;
   logic [DW-1:0]     rd_value;
   // Response registers
   logic              wr_done_q;
   logic              rd_valid_q;
   logic              err_q;
   logic [DW-1:0]     rdata_q;

   // Clear starts with the accepted reset write
   assign srst_start  = wr_ok && (reg_req.idx == `REG_RESET);
   assign srst_active = (srst_cnt != '0);
   assign fifo_clear  = srst_active || srst_start;
   assign sys_resetn  = !srst_active;

   // A FIFO that plays or is about to play cannot take loads
   assign f0_blocked = (active == SEL_F0) || (on_deck == SEL_F0) || (f0_stat.count == FULL_CNT);
   assign f1_blocked = (active == SEL_F1) || (on_deck == SEL_F1) || (f1_stat.count == FULL_CNT);

   //==================================================
   // Write and read decode
   //==================================================
   always_comb begin
      case (reg_req.idx)
         `REG_RESET:       wr_err = 1'b0;
         `REG_LOAD_F0:     wr_err = f0_blocked;
         `REG_LOAD_F1:     wr_err = f1_blocked;
         // Only 0, 1 and 2 are legal start values
         `REG_START:       wr_err = (reg_req.wdata > DW'(2));
         `REG_CONT_MODE:   wr_err = 1'b0;
         `REG_NSHOT_LIMIT: wr_err = 1'b0;
         // Version is read-only, everything else is unmapped
         default:          wr_err = 1'b1;
      endcase
      // Register file is locked during soft reset
      if (srst_active) begin
         wr_err = 1'b1;
      end
   end

   assign wr_ok = reg_req.wr && !wr_err;

   always_comb begin
      rd_err   = 1'b0;
      rd_value = '0;
      case (reg_req.idx)
         `REG_VERSION:     rd_value = DW'(`STREAM_VERSION);
         `REG_RESET:       rd_value = DW'(srst_active);
         `REG_LOAD_F0:     rd_value = DW'(f0_stat.count);
         `REG_LOAD_F1:     rd_value = DW'(f1_stat.count);
         `REG_START:       rd_value = DW'(active);
         `REG_CONT_MODE:   rd_value = DW'(cont_mode);
         `REG_NSHOT_LIMIT: rd_value = nshot_limit;
         default:          rd_err   = 1'b1;
      endcase
   end

   //==================================================
   // Control registers
   //==================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         srst_cnt    <= '0;
         on_deck     <= SEL_NONE;
         cont_mode   <= 1'b1;
         nshot_limit <= DW'(1);
         load_f0     <= 1'b0;
         load_f1     <= 1'b0;
         wr_done_q   <= 1'b0;
         rd_valid_q  <= 1'b0;
      end else begin
         load_f0    <= 1'b0;
         load_f1    <= 1'b0;
         wr_done_q  <= reg_req.wr;
         rd_valid_q <= reg_req.rd;

         if (srst_active) begin
            srst_cnt <= srst_cnt - 1'b1;
         end

         // N-shot playback never repeats, so nothing stays on deck
         if ((active != SEL_NONE) && !cont_mode) begin
            on_deck <= SEL_NONE;
         end

         if (wr_ok) begin
            case (reg_req.idx)
               `REG_RESET: begin
                  srst_cnt    <= SRST_W'(`STREAM_SRST_CYCLES);
                  on_deck     <= SEL_NONE;
                  cont_mode   <= 1'b1;
                  nshot_limit <= DW'(1);
               end
               `REG_LOAD_F0: load_f0 <= 1'b1;
               `REG_LOAD_F1: load_f1 <= 1'b1;
               `REG_START: begin
                  // Start of an empty FIFO is dropped quietly
                  if (reg_req.wdata[1:0] == 2'd0) begin
                     on_deck <= SEL_NONE;
                  end else if ((reg_req.wdata[1:0] == 2'd1) && f0_stat.nonempty) begin
                     on_deck <= SEL_F0;
                  end else if ((reg_req.wdata[1:0] == 2'd2) && f1_stat.nonempty) begin
                     on_deck <= SEL_F1;
                  end
               end
               `REG_CONT_MODE:   cont_mode   <= reg_req.wdata[0];
               `REG_NSHOT_LIMIT: nshot_limit <= reg_req.wdata;
               default: ;
            endcase
         end
      end
   end

   // Response payload and load word
   always_ff @(posedge clk) begin
      err_q   <= (reg_req.wr && wr_err) || (reg_req.rd && rd_err);
      rdata_q <= reg_req.rd ? rd_value : '0;
      if (wr_ok) begin
         load_data <= reg_req.wdata;
      end
   end

   assign reg_rsp.wr_done  = wr_done_q;
   assign reg_rsp.rd_valid = rd_valid_q;
   assign reg_rsp.err      = err_q;
   assign reg_rsp.rdata    = rdata_q;

endmodule

/* design/stream_sequencer.sv */
`timescale 1ns/10ps
`include "streamer_params.svh"

module stream_sequencer
   import streamer_pkg::*;
(
   input  logic                      clk,
   input  logic                      resetn,
   input  logic                      clear,
   input  fifo_sel_t                 on_deck,
   input  logic                      cont_mode,
   input  logic [`STREAM_DATA_W-1:0] nshot_limit,
   input  fifo_stat_t                f0_stat,
   input  fifo_stat_t                f1_stat,
   input  logic [`STREAM_DATA_W-1:0] f0_data,
   input  logic [`STREAM_DATA_W-1:0] f1_data,
   output fifo_sel_t                 active,
   output logic                      pop_f0,
   output logic                      pop_f1,
   output logic [`STREAM_DATA_W-1:0] stream_data,
   output logic                      stream_valid,
   input  logic                      stream_ready
);

   localparam int DW    = `STREAM_DATA_W;
   localparam int CNT_W = `STREAM_CNT_W;

   // Words left in the current pass, including the one on the bus
   logic [CNT_W-1:0] word_cnt;
   // Passes left in N-shot mode, including the current one
   logic [DW-1:0]    pass_left;
   logic [DW-1:0]    first_passes;
   fifo_stat_t       cur_stat;
   logic             xfer;
   logic             last_word;

   assign cur_stat     = (active == SEL_F1) ? f1_stat : f0_stat;
   assign xfer         = stream_valid && stream_ready;
   assign last_word    = (word_cnt == CNT_W'(1));
   // A limit of zero plays once
   assign first_passes = (nshot_limit == '0) ? DW'(1) : nshot_limit;

   // Head word of the active FIFO goes straight to the bus
   always_comb begin
      case (active)
         SEL_F0:  stream_data = f0_data;
         SEL_F1:  stream_data = f1_data;
         default: stream_data = '0;
      endcase
   end

   // Each transfer pops and writes back the same word
   assign pop_f0 = xfer && (active == SEL_F0);
   assign pop_f1 = xfer && (active == SEL_F1);

   //==================================================
   // Output FSM
   //==================================================
   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         active       <= SEL_NONE;
         stream_valid <= 1'b0;
         word_cnt     <= '0;
         pass_left    <= '0;
      end else if (!stream_valid || (xfer && last_word && cont_mode)) begin
         // Idle, or a pass boundary in continuous mode
         if ((on_deck == SEL_F0) && f0_stat.nonempty) begin
            active       <= SEL_F0;
            stream_valid <= 1'b1;
            word_cnt     <= f0_stat.count;
            pass_left    <= first_passes;
         end else if ((on_deck == SEL_F1) && f1_stat.nonempty) begin
            active       <= SEL_F1;
            stream_valid <= 1'b1;
            word_cnt     <= f1_stat.count;
            pass_left    <= first_passes;
         end else begin
            active       <= SEL_NONE;
            stream_valid <= 1'b0;
         end
      end else if (xfer) begin
         if (!last_word) begin
            word_cnt <= word_cnt - 1'b1;
         end else if (pass_left > DW'(1)) begin
            // N-shot pass boundary with passes still to go
            word_cnt  <= cur_stat.count;
            pass_left <= pass_left - 1'b1;
         end else begin
            active       <= SEL_NONE;
            stream_valid <= 1'b0;
         end
      end
   end

endmodule

/* design/streamer_pkg.sv */
`include "streamer_params.svh"

package streamer_pkg;

   //==================================================
   // Register port
   //==================================================
   // Single-cycle request strobe, wr and rd never high together
   typedef struct packed {
      logic                         wr;
      logic                         rd;
      logic [`STREAM_REG_IDX_W-1:0] idx;
      logic [`STREAM_DATA_W-1:0]    wdata;
   } reg_req_t;

   // One-cycle response, one cycle after the strobe
   typedef struct packed {
      logic                      wr_done;
      logic                      rd_valid;
      logic                      err;
      logic [`STREAM_DATA_W-1:0] rdata;
   } reg_rsp_t;

   //==================================================
   // Pattern FIFO selection and status
   //==================================================
   // Encoding matches the START register value
   typedef enum logic [1:0] {
      SEL_NONE = 2'd0,
      SEL_F0   = 2'd1,
      SEL_F1   = 2'd2
   } fifo_sel_t;

   typedef struct packed {
      logic [`STREAM_CNT_W-1:0] count;
      logic                     nonempty;
   } fifo_stat_t;

endpackage

/* include/streamer_params.svh */
`ifndef STREAMER_PARAMS_SVH
`define STREAMER_PARAMS_SVH

//==================================================
// Data path and storage sizes
//==================================================
// Pattern word and register data width
`define STREAM_DATA_W       32
`define STREAM_REG_IDX_W    4
// Words held by each pattern FIFO
`define STREAM_FIFO_DEPTH   16
// Must be able to hold the full depth value
`define STREAM_CNT_W        5

// Cycles that sys_resetn stays low after a soft reset
`define STREAM_SRST_CYCLES  15
// Bump whenever the register map changes
`define STREAM_VERSION      1

//==================================================
// Register indices
//==================================================
`define REG_VERSION         4'd0
`define REG_RESET           4'd1
`define REG_LOAD_F0         4'd2
`define REG_LOAD_F1         4'd3
`define REG_START           4'd4
`define REG_CONT_MODE       4'd5
`define REG_NSHOT_LIMIT     4'd6

`endif

/* sim.f */
+incdir+include
design/streamer_pkg.sv
design/pattern_fifo.sv
design/stream_regs.sv
design/stream_sequencer.sv
design/pattern_streamer.sv
verif/pattern_streamer_sva.sv
verif/pattern_streamer_tb.sv

/* verif/pattern_streamer_sva.sv */
`timescale 1ns/10ps
`include "streamer_params.svh"

module pattern_streamer_sva
   import streamer_pkg::*;
(
   input logic                      clk,
   input logic                      resetn,
   input reg_req_t                  reg_req,
   input reg_rsp_t                  reg_rsp,
   input logic [`STREAM_DATA_W-1:0] stream_data,
   input logic                      stream_valid,
   input logic                      stream_ready,
   input logic                      sys_resetn
);

   // Failed assertions, read by the testbench for its summary
   int assert_fails = 0;

   // ==================================================
   // Output stream
   // ==================================================
   // Word held until taken, soft reset may drop it
   valid_hold: assert property (@(posedge clk) disable iff (!resetn)
      (stream_valid && !stream_ready)
         |=> (!sys_resetn || (stream_valid && $stable(stream_data))))
      else begin
         assert_fails++;
         $error("stream word dropped or changed before ready");
      end

   // Valid low for the whole soft reset
   idle_in_srst: assert property (@(posedge clk) disable iff (!resetn)
      !sys_resetn |-> !stream_valid)
      else begin
         assert_fails++;
         $error("stream_valid high during soft reset");
      end

   // ==================================================
   // Register port
   // ==================================================
   rd_rsp: assert property (@(posedge clk) disable iff (!resetn)
      reg_rsp.rd_valid == $past(reg_req.rd))
      else begin
         assert_fails++;
         $error("rd_valid not one cycle after the read strobe");
      end

   wr_rsp: assert property (@(posedge clk) disable iff (!resetn)
      reg_rsp.wr_done == $past(reg_req.wr))
      else begin
         assert_fails++;
         $error("wr_done not one cycle after the write strobe");
      end

endmodule

/* verif/pattern_streamer_tb.sv */
`timescale 1ns/10ps
`include "streamer_params.svh"

module pattern_streamer_tb
   import streamer_pkg::*;
();

   localparam int DW = `STREAM_DATA_W;
   // Rough upper bound on the directed tests, plus slack
   localparam int TEST_CYCLES     = 4000;
   localparam int MARGIN_CYCLES   = 16000;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + MARGIN_CYCLES;

   logic            clk;
   logic            resetn;
   reg_req_t        reg_req;
   reg_rsp_t        reg_rsp;
   logic [DW-1:0]   stream_data;
   logic            stream_valid;
   logic            stream_ready;
   logic            sys_resetn;

   int              errors;
   // Words taken from the stream, and the words last loaded
   logic [DW-1:0]   got_q[$];
   logic [DW-1:0]   load_q[$];
   // Reference patterns per FIFO, in load order
   logic [DW-1:0]   f0_pat[$];
   logic [DW-1:0]   f1_pat[$];

   pattern_streamer pattern_streamer_inst (
      .clk          (clk),
      .resetn       (resetn),
      .reg_req      (reg_req),
      .reg_rsp      (reg_rsp),
      .stream_data  (stream_data),
      .stream_valid (stream_valid),
      .stream_ready (stream_ready),
      .sys_resetn   (sys_resetn)
   );

   bind pattern_streamer pattern_streamer_sva pattern_streamer_sva_inst (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // ==================================================
   // Checks and register access
   // ==================================================
   task automatic check(input logic [DW-1:0] got, input logic [DW-1:0] exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s (got 0x%0h, expected 0x%0h)", $time, what, got, exp);
      end
   endtask

   // Strobe for one cycle, response sampled one cycle later
   task automatic reg_write(input logic [3:0] idx, input logic [DW-1:0] data, output logic err);
      @(negedge clk);
      reg_req.wr    = 1'b1;
      reg_req.idx   = idx;
      reg_req.wdata = data;
      @(negedge clk);
      reg_req = '0;
      check(DW'(reg_rsp.wr_done), DW'(1), "write response strobe");
      err = reg_rsp.err;
   endtask

   task automatic reg_read(input logic [3:0] idx, output logic [DW-1:0] data, output logic err);
      @(negedge clk);
      reg_req.rd  = 1'b1;
      reg_req.idx = idx;
      @(negedge clk);
      reg_req = '0;
      check(DW'(reg_rsp.rd_valid), DW'(1), "read response strobe");
      data = reg_rsp.rdata;
      err  = reg_rsp.err;
   endtask

   task automatic write_expect(input logic [3:0] idx, input logic [DW-1:0] data,
                               input logic exp_err, input string what);
      logic err;
      reg_write(idx, data, err);
      check(DW'(err), DW'(exp_err), what);
   endtask

   task automatic read_expect(input logic [3:0] idx, input logic [DW-1:0] exp_value,
                              input string what);
      logic [DW-1:0] value;
      logic          err;
      reg_read(idx, value, err);
      check(DW'(err), DW'(0), {what, " err flag"});
      check(value, exp_value, what);
   endtask

   // Random words into one FIFO, then count read-back
   task automatic load_pattern(input int fifo, input int n);
      logic [DW-1:0] word;
      load_q.delete();
      for (int i = 0; i < n; i++) begin
         word = $urandom();
         load_q.push_back(word);
         write_expect((fifo == 0) ? `REG_LOAD_F0 : `REG_LOAD_F1, word, 1'b0, "load accepted");
      end
      read_expect((fifo == 0) ? `REG_LOAD_F0 : `REG_LOAD_F1, DW'(n), "FIFO count after load");
   endtask

   // ==================================================
   // Stream capture
   // ==================================================
   // Ready from a rotating stall mask; ends on word count or 8 idle cycles
   task automatic collect_words(input int max_words, input logic [31:0] stall_mask);
      int idle;
      int cycles;
      idle   = 0;
      cycles = 0;
      got_q.delete();
      while ((got_q.size() < max_words) && (idle < 8) && (cycles < 2000)) begin
         @(negedge clk);
         stream_ready = !stall_mask[cycles[4:0]];
         // Valid and ready both stable here, transfer at the next rising edge
         if (stream_valid && stream_ready) begin
            got_q.push_back(stream_data);
         end
         idle = stream_valid ? 0 : idle + 1;
         cycles++;
      end
      // Let the last accepted word complete
      @(negedge clk);
      stream_ready = 1'b0;
      if (cycles >= 2000) begin
         errors++;
         $display("Error: stream capture did not finish within 2000 cycles");
      end
   endtask

   // True when got_q holds one whole pass of a FIFO pattern at start
   function automatic bit pass_at(input int start, input int fifo);
      int n;
      n = (fifo == 0) ? f0_pat.size() : f1_pat.size();
      if ((n == 0) || (start + n > got_q.size())) begin
         return 1'b0;
      end
      for (int k = 0; k < n; k++) begin
         if (got_q[start+k] !== ((fifo == 0) ? f0_pat[k] : f1_pat[k])) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   task automatic check_repeats(input int fifo, input int passes);
      int n;
      n = (fifo == 0) ? f0_pat.size() : f1_pat.size();
      check(DW'(got_q.size()), DW'(n * passes), "streamed word count");
      for (int p = 0; p < passes; p++) begin
         check(DW'(pass_at(p * n, fifo)), DW'(1), $sformatf("pass %0d contents", p));
      end
   endtask

   task automatic expect_idle(input int n);
      repeat (n) begin
         @(negedge clk);
         check(DW'(stream_valid), DW'(0), "stream idle");
      end
      read_expect(`REG_START, DW'(SEL_NONE), "START after playback");
   endtask

   task automatic wait_sys_reset(output int cycles);
      cycles = 0;
      while (!sys_resetn && (cycles < 100)) begin
         @(negedge clk);
         cycles++;
      end
      if (!sys_resetn) begin
         errors++;
         $display("Error: sys_resetn did not return high after the soft reset");
      end
   endtask

   // ==================================================
   // Directed tests
   // ==================================================
   task automatic test_defaults();
      logic [DW-1:0] value;
      logic          err;
      read_expect(`REG_VERSION, DW'(`STREAM_VERSION), "version");
      read_expect(`REG_CONT_MODE, DW'(1), "default cont_mode");
      read_expect(`REG_NSHOT_LIMIT, DW'(1), "default nshot limit");
      read_expect(`REG_LOAD_F0, DW'(0), "F0 count after reset");
      read_expect(`REG_LOAD_F1, DW'(0), "F1 count after reset");
      read_expect(`REG_START, DW'(0), "START after reset");
      // Unmapped index
      reg_read(4'hf, value, err);
      check(DW'(err), DW'(1), "unknown index err");
      check(value, DW'(0), "unknown index rdata");
   endtask

   task automatic test_nshot();
      load_pattern(0, 5);
      f0_pat = load_q;
      write_expect(`REG_CONT_MODE, DW'(0), 1'b0, "select N-shot");
      write_expect(`REG_NSHOT_LIMIT, DW'(3), 1'b0, "nshot limit");
      write_expect(`REG_START, DW'(1), 1'b0, "start F0");
      collect_words(15, 32'h0);
      check_repeats(0, 3);
      expect_idle(8);
   endtask

   task automatic test_backpressure();
      load_pattern(1, 5);
      f1_pat = load_q;
      write_expect(`REG_START, DW'(2), 1'b0, "start F1");
      collect_words(15, $urandom());
      check_repeats(1, 3);
      expect_idle(8);
   endtask

   task automatic test_continuous();
      int rst_cycles;
      int pos;
      int f1_passes;
      int f0_passes;
      // Soft reset empties both FIFOs
      write_expect(`REG_RESET, DW'(1), 1'b0, "soft reset write");
      wait_sys_reset(rst_cycles);
      check(DW'(rst_cycles), DW'(`STREAM_SRST_CYCLES), "soft reset length");
      write_expect(`REG_CONT_MODE, DW'(1), 1'b0, "select continuous");
      load_pattern(1, 4);
      f1_pat = load_q;
      load_pattern(0, 3);
      f0_pat = load_q;
      write_expect(`REG_START, DW'(2), 1'b0, "start F1");
      fork
         collect_words(1000, $urandom() & $urandom());
         begin
            @(negedge clk);
            while (got_q.size() < 6) @(negedge clk);
            write_expect(`REG_START, DW'(1), 1'b0, "switch to F0");
            while (got_q.size() < 20) @(negedge clk);
            write_expect(`REG_START, DW'(0), 1'b0, "stop stream");
         end
      join
      // Whole F1 passes, then whole F0 passes, nothing left over
      pos       = 0;
      f1_passes = 0;
      f0_passes = 0;
      while (pass_at(pos, 1)) begin
         pos += f1_pat.size();
         f1_passes++;
      end
      while (pass_at(pos, 0)) begin
         pos += f0_pat.size();
         f0_passes++;
      end
      check(DW'(pos), DW'(got_q.size()), "stream ends on a pass boundary");
      check(DW'(f1_passes > 0), DW'(1), "F1 passes seen");
      check(DW'(f0_passes > 0), DW'(1), "F0 passes seen");
      expect_idle(4);
   endtask

   task automatic test_soft_reset();
      int cycles;
      stream_ready = 1'b0;
      write_expect(`REG_START, DW'(1), 1'b0, "start F0 under stall");
      // Valid due within three cycles of the write taking effect
      cycles = 0;
      while (!stream_valid && (cycles < 3)) begin
         @(negedge clk);
         cycles++;
      end
      check(DW'(stream_valid), DW'(1), "stream starts within start latency");
      write_expect(`REG_LOAD_F0, 32'h1234_5678, 1'b1, "load to active FIFO");
      read_expect(`REG_LOAD_F0, DW'(f0_pat.size()), "F0 count after rejected load");
      write_expect(`REG_RESET, DW'(1), 1'b0, "soft reset write");
      check(DW'(sys_resetn), DW'(0), "sys_resetn low in soft reset");
      check(DW'(stream_valid), DW'(0), "stream stopped by soft reset");
      write_expect(`REG_CONT_MODE, DW'(0), 1'b1, "write during soft reset");
      read_expect(`REG_RESET, DW'(1), "RESET readback in soft reset");
      wait_sys_reset(cycles);
      read_expect(`REG_LOAD_F0, DW'(0), "F0 count after soft reset");
      read_expect(`REG_LOAD_F1, DW'(0), "F1 count after soft reset");
      check(DW'(stream_valid), DW'(0), "stream idle after soft reset");
      read_expect(`REG_START, DW'(0), "START after soft reset");
   endtask

   // ==================================================
   // Run control
   // ==================================================
   initial begin
      void'($urandom(89));
      errors       = 0;
      reg_req      = '0;
      stream_ready = 1'b0;
      resetn       = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;

      test_defaults();
      test_nshot();
      test_backpressure();
      test_continuous();
      test_soft_reset();

      repeat (4) @(negedge clk);
      $display("Summary: %0d check errors, %0d assertion failures", errors,
               pattern_streamer_inst.pattern_streamer_sva_inst.assert_fails);
      if ((errors == 0) && (pattern_streamer_inst.pattern_streamer_sva_inst.assert_fails == 0)) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule
